// ==== src.f ====
hw/arcade_pkg.sv
hw/rom_loader.sv
hw/rom_arbiter.sv
hw/rom_store.sv
hw/soft_reset.sv
hw/input_cond.sv
hw/core_shell.sv
tests/core_checker.sv
tests/tb_core_shell.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build the board shell testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_core_shell \
    -o sim_core_shell
./obj_dir/sim_core_shell | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/tb_core_shell.sv ====
// ****************************************
// Board shell testbench with stimulus,
// reference model, watchdog and report
// ****************************************
`timescale 1ns/1ns

module tb_core_shell;
    import arcade_pkg::*;

    localparam int ROM_AW      = 11;
    localparam int CLK_NS      = 40;
    localparam int TEST_CYCLES = 500;   // Summed length of all tests
    localparam int MARGIN_NS   = 4000;

    logic       clk_rgb = 1'b0;
    logic       rst;
    logic       dl_stb;
    dl_byte_t   dl;
    logic       downloading;
    logic       rst_req;
    logic       rd_stb;
    logic [15:0] rd_addr;
    logic [15:0] rd_exp;
    logic       rd_valid;
    logic [15:0] rd_data;
    logic       prom_stb;
    prom_prog_t prom;
    logic       prom_exp_vld;
    prom_prog_t prom_exp;
    logic       soft_rst;
    btn_in_t    joy;
    btn_in_t    key;
    game_in_t   game_in;
    int         err_cnt;
    int         chk_cnt;
    int         rd_pend;

    logic [15:0] rom_model [2**ROM_AW];
    logic [7:0]  lo_model;
    int          written[$];     // Word addresses holding known data
    int          seed = 26686;
    int          err_before;
    int          n;
    int          waddr;

    always #(CLK_NS / 2) clk_rgb = ~clk_rgb;

    core_shell #(.ROM_AW(ROM_AW), .SOFT_RST_CYCLES(16)) i_core_shell (
        .clk_rgb(clk_rgb), .rst(rst), .dl_stb_i(dl_stb), .dl_i(dl),
        .downloading_i(downloading), .rst_req_i(rst_req),
        .rd_stb_i(rd_stb), .rd_addr_i(rd_addr),
        .rd_valid_o(rd_valid), .rd_data_o(rd_data),
        .prom_stb_o(prom_stb), .prom_o(prom), .soft_rst_o(soft_rst),
        .joy_i(joy), .key_i(key), .game_in_o(game_in)
    );

    core_checker i_checker (
        .clk_rgb(clk_rgb), .rst(rst), .dl_stb_i(dl_stb),
        .downloading_i(downloading), .rst_req_i(rst_req),
        .rd_stb_i(rd_stb), .rd_exp_i(rd_exp),
        .rd_valid_i(rd_valid), .rd_data_i(rd_data),
        .prom_exp_vld_i(prom_exp_vld), .prom_exp_i(prom_exp),
        .prom_stb_i(prom_stb), .prom_i(prom), .soft_rst_i(soft_rst),
        .joy_i(joy), .key_i(key), .game_in_i(game_in),
        .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt), .rd_pend_o(rd_pend)
    );

    // Reference for the store contents
    function automatic logic [15:0] expected_word(input int word_addr);
        return rom_model[word_addr];
    endfunction

    function automatic prom_prog_t expected_prom(input dl_addr_u a, input logic [7:0] d);
        prom_prog_t p;
        p.we              = '0;
        p.we[a.prom.idx]  = 1'b1;   // One bit per PROM
        p.addr            = a.prom.offset;
        p.data            = d[3:0];
        return p;
    endfunction

    task automatic apply_byte(input dl_addr_u a, input logic [7:0] d);
        if (a.prom.tag != PROM_TAG && int'(a.flat) < 2 * (2**ROM_AW)) begin
            if (!a.flat[0]) begin
                lo_model = d;
            end else begin
                rom_model[a.flat[15:1]] = {d, lo_model};
            end
        end
    endtask

    task automatic tick();
        @(posedge clk_rgb);
    endtask

    // One download byte and an optional read that meets its write
    task automatic send_byte(input logic [15:0] addr, input logic [7:0] data,
                             input logic with_read, input int raddr);
        dl_addr_u a;
        a.flat = addr;
        dl_stb       <= 1'b1;
        dl.addr      <= a;
        dl.data      <= data;
        prom_exp_vld <= (a.prom.tag == PROM_TAG);
        prom_exp     <= expected_prom(a, data);
        apply_byte(a, data);
        tick();
        dl_stb       <= 1'b0;
        prom_exp_vld <= 1'b0;
        if (with_read) begin
            rd_stb  <= 1'b1;
            rd_addr <= 16'(raddr);
            rd_exp  <= expected_word(raddr);
        end
        tick();
        rd_stb <= 1'b0;
    endtask

    task automatic read_word(input int raddr);
        rd_stb  <= 1'b1;
        rd_addr <= 16'(raddr);
        rd_exp  <= expected_word(raddr);
        tick();
        rd_stb <= 1'b0;
        tick();
    endtask

    task automatic wait_reads();
        int k;
        for (k = 0; k < 10 && (rd_pend != 0 || rd_stb); k++) tick();
        tick();
    endtask

    task automatic end_test(input string name);
        $display("%s finished, %0d new errors", name, err_cnt - err_before);
        err_before = err_cnt;
    endtask

    initial begin
        #(TEST_CYCLES * CLK_NS + MARGIN_NS);
        $display("timeout: the tests did not complete in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        dl_stb       = 1'b0;
        dl           = '0;
        downloading  = 1'b0;
        rst_req      = 1'b0;
        rd_stb       = 1'b0;
        rd_addr      = '0;
        rd_exp       = '0;
        prom_exp_vld = 1'b0;
        prom_exp     = '0;
        joy          = '0;
        key          = '0;
        lo_model     = '0;
        err_before   = 0;
        repeat (4) tick();
        rst <= 1'b0;

        // Idle outputs after reset
        repeat (8) tick();
        end_test("test 1 reset state");

        // Random words at random ROM addresses
        downloading <= 1'b1;
        for (n = 0; n < 32; n++) begin
            waddr = $unsigned($random(seed)) % (2**ROM_AW);
            send_byte(16'(2 * waddr), 8'($random(seed)), 1'b0, 0);
            send_byte(16'(2 * waddr + 1), 8'($random(seed)), 1'b0, 0);
            written.push_back(waddr);
        end
        foreach (written[i]) read_word(written[i]);
        wait_reads();
        end_test("test 2 ROM download and readback");

        // PROM bytes then a word past the ROM range
        for (n = 0; n < 8; n++) begin
            send_byte({PROM_TAG, 4'($random(seed)), 8'($random(seed))},
                      8'($random(seed)), 1'b0, 0);
        end
        // Same low address bits as a written word
        send_byte(16'(2 * (2**ROM_AW) + 2 * written[0]), 8'h5a, 1'b0, 0);
        send_byte(16'(2 * (2**ROM_AW) + 2 * written[0] + 1), 8'ha5, 1'b0, 0);
        foreach (written[i]) read_word(written[i]);
        wait_reads();
        end_test("test 3 PROM bytes and ignored range");

        // Reads colliding with word writes
        for (n = 0; n < 16; n++) begin
            waddr = $unsigned($random(seed)) % (2**ROM_AW);
            send_byte(16'(2 * waddr), 8'($random(seed)), 1'b0, 0);
            written.push_back(waddr);
            send_byte(16'(2 * waddr + 1), 8'($random(seed)), 1'b1,
                      written[$unsigned($random(seed)) % written.size()]);
        end
        wait_reads();
        end_test("test 4 reads against writes");

        // Download end and host reset request
        downloading <= 1'b0;
        for (n = 0; n < 30; n++) begin
            rst_req <= 1'($random(seed));
            tick();
        end
        downloading <= 1'b1;
        repeat (3) tick();
        downloading <= 1'b0;
        for (n = 0; n < 25; n++) begin
            rst_req <= 1'($random(seed));
            tick();
        end
        rst_req <= 1'b0;
        tick();
        end_test("test 5 soft reset");

        // Random buttons from both sources
        for (n = 0; n < 40; n++) begin
            joy <= btn_in_t'(16'($random(seed)));
            key <= btn_in_t'(16'($random(seed)));
            tick();
        end
        joy <= '0;
        key <= '0;
        repeat (3) tick();
        end_test("test 6 input merge");

        @(negedge clk_rgb);     // Counts from the last edge settle
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tests/core_checker.sv ====
// ****************************************
// Port monitor for the board shell: read data,
// PROM strobes, soft reset and game inputs
// ****************************************
`timescale 1ns/1ns

module core_checker (
    input  logic                   clk_rgb,
    input  logic                   rst,
    input  logic                   dl_stb_i,
    input  logic                   downloading_i,
    input  logic                   rst_req_i,
    input  logic                   rd_stb_i,
    input  logic [15:0]            rd_exp_i,    // Expected word for this read
    input  logic                   rd_valid_i,
    input  logic [15:0]            rd_data_i,
    input  logic                   prom_exp_vld_i,
    input  arcade_pkg::prom_prog_t prom_exp_i,
    input  logic                   prom_stb_i,
    input  arcade_pkg::prom_prog_t prom_i,
    input  logic                   soft_rst_i,
    input  arcade_pkg::btn_in_t    joy_i,
    input  arcade_pkg::btn_in_t    key_i,
    input  arcade_pkg::game_in_t   game_in_i,
    output int                     err_cnt_o,
    output int                     chk_cnt_o,
    output int                     rd_pend_o
);
    import arcade_pkg::*;

    logic [15:0] exp_q[$];      // Outstanding reads, oldest first
    int          age_q[$];
    logic        prom_due;
    prom_prog_t  prom_want;
    logic        exp_soft;
    int          soft_left;
    logic        dl_prev;
    game_in_t    exp_game;
    logic        armed = 1'b0;
    int          errs = 0;
    int          checks = 0;
    logic [15:0] got_word;

    task automatic flag_mismatch(input string msg);
        $display("mismatch %0t ns: %s", $time, msg);
        errs++;
    endtask

    task automatic flag_failure(input string msg);
        $display("failure at %0t ns: %s", $time, msg);
        errs++;
    endtask

    always @(posedge clk_rgb) begin
        if (rst) begin
            armed    = 1'b1;
            exp_q.delete();
            age_q.delete();
            prom_due = 1'b0;
            exp_soft = 1'b0;
            soft_left = 0;
            dl_prev  = 1'b0;
            exp_game = '1;
        end else if (armed) begin
            // Returned read data, in request order
            if (rd_valid_i) begin
                if (exp_q.size() == 0) begin
                    flag_failure("rd_valid_o pulsed with no read outstanding");
                end else begin
                    got_word = exp_q.pop_front();
                    void'(age_q.pop_front());
                    checks++;
                    if (rd_data_i !== got_word)
                        flag_mismatch($sformatf("rd_data_o %h, expected %h",
                                                rd_data_i, got_word));
                end
            end
            foreach (age_q[i]) age_q[i]++;
            if (age_q.size() > 0 && age_q[0] >= 3) begin
                flag_failure("no rd_valid_o within 3 cycles of a read request");
                void'(exp_q.pop_front());
                void'(age_q.pop_front());
            end
            if (rd_stb_i) begin
                exp_q.push_back(rd_exp_i);
                age_q.push_back(0);
            end

            // PROM strobe one cycle after its byte
            if (prom_due) begin
                checks++;
                if (!prom_stb_i)
                    flag_failure("PROM byte produced no prom_stb_o");
                else if (prom_i !== prom_want)
                    flag_mismatch($sformatf("prom_o %h, expected %h", prom_i, prom_want));
            end else if (prom_stb_i) begin
                flag_failure("prom_stb_o pulsed without a PROM byte");
            end
            prom_due  = dl_stb_i && prom_exp_vld_i;
            prom_want = prom_exp_i;

            checks++;
            if (soft_rst_i !== exp_soft)
                flag_mismatch($sformatf("soft_rst_o %b, expected %b", soft_rst_i, exp_soft));
            checks++;
            if (game_in_i !== exp_game)
                flag_mismatch($sformatf("game_in_o %h, expected %h", game_in_i, exp_game));
        end

        // Next expected soft reset, a fixed window after a download ends
        if (!rst && armed) begin
            if (dl_prev && !downloading_i) begin
                exp_soft  = 1'b1;
                soft_left = 15;
            end else if (soft_left > 0) begin
                exp_soft  = 1'b1;
                soft_left--;
            end else begin
                exp_soft = rst_req_i;
            end
            dl_prev  = downloading_i;
            exp_game = game_in_t'(~(16'(joy_i) | 16'(key_i)));
        end

        err_cnt_o <= errs;
        chk_cnt_o <= checks;
        rd_pend_o <= exp_q.size();
    end

endmodule

// ==== hw/core_shell.sv ====
// ****************************************
// Board shell top: loader, arbiter, store,
// soft reset and input conditioning
// ****************************************
`timescale 1ns/1ns

module core_shell #(
    parameter int ROM_AW          = 11,
    parameter int SOFT_RST_CYCLES = 16
) (
    input  logic                   clk_rgb,
    input  logic                   rst,
    input  logic                   dl_stb_i,
    input  arcade_pkg::dl_byte_t   dl_i,
    input  logic                   downloading_i,
    input  logic                   rst_req_i,
    input  logic                   rd_stb_i,
    input  logic [15:0]            rd_addr_i,
    output logic                   rd_valid_o,
    output logic [15:0]            rd_data_o,
    output logic                   prom_stb_o,
    output arcade_pkg::prom_prog_t prom_o,
    output logic                   soft_rst_o,
    input  arcade_pkg::btn_in_t    joy_i,
    input  arcade_pkg::btn_in_t    key_i,
    output arcade_pkg::game_in_t   game_in_o
);
    import arcade_pkg::*;

    logic        wr_stb;
    mem_req_t    wr_req;    // Loader word write
    logic        mem_en;
    mem_req_t    mem_req;   // Granted store access
    logic [15:0] mem_rdata;

    rom_loader #(.ROM_AW(ROM_AW)) i_rom_loader (
        .clk_rgb    ( clk_rgb    ),
        .rst        ( rst        ),
        .dl_stb_i   ( dl_stb_i   ),
        .dl_i       ( dl_i       ),
        .prom_stb_o ( prom_stb_o ),
        .prom_o     ( prom_o     ),
        .wr_stb_o   ( wr_stb     ),
        .wr_req_o   ( wr_req     )
    );

    rom_arbiter i_rom_arbiter (
        .clk_rgb     ( clk_rgb    ),
        .rst         ( rst        ),
        .wr_stb_i    ( wr_stb     ),
        .wr_req_i    ( wr_req     ),
        .rd_stb_i    ( rd_stb_i   ),
        .rd_addr_i   ( rd_addr_i  ),
        .mem_en_o    ( mem_en     ),
        .mem_req_o   ( mem_req    ),
        .mem_rdata_i ( mem_rdata  ),
        .rd_valid_o  ( rd_valid_o ),
        .rd_data_o   ( rd_data_o  )
    );

    rom_store #(.ROM_AW(ROM_AW)) i_rom_store (
        .clk_rgb ( clk_rgb   ),
        .en_i    ( mem_en    ),
        .req_i   ( mem_req   ),
        .rdata_o ( mem_rdata )
    );

    soft_reset #(.SOFT_RST_CYCLES(SOFT_RST_CYCLES)) i_soft_reset (
        .clk_rgb       ( clk_rgb       ),
        .rst           ( rst           ),
        .downloading_i ( downloading_i ),
        .rst_req_i     ( rst_req_i     ),
        .soft_rst_o    ( soft_rst_o    )
    );

    input_cond i_input_cond (
        .clk_rgb   ( clk_rgb   ),
        .rst       ( rst       ),
        .joy_i     ( joy_i     ),
        .key_i     ( key_i     ),
        .game_in_o ( game_in_o )
    );

endmodule

// ==== hw/input_cond.sv ====
// ****************************************
// Joystick and keyboard merge to
// active-low game inputs
// ****************************************
`timescale 1ns/1ns

module input_cond (
    input  logic                 clk_rgb,
    input  logic                 rst,
    input  arcade_pkg::btn_in_t  joy_i,
    input  arcade_pkg::btn_in_t  key_i,
    output arcade_pkg::game_in_t game_in_o
);

    // Pressed on either source pulls the line low
    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            game_in_o <= '1;    // Nothing pressed
        end else begin
            game_in_o.joy1  <= ~(joy_i.joy1 | key_i.joy1);
            game_in_o.joy2  <= ~(joy_i.joy2 | key_i.joy2);
            game_in_o.start <= ~(joy_i.start | key_i.start);
            game_in_o.coin  <= ~(joy_i.coin | key_i.coin);
        end
    end

endmodule

// ==== hw/soft_reset.sv ====
// ****************************************
// Game reset after a download ends,
// then host reset request
// ****************************************
`timescale 1ns/1ns

module soft_reset #(
    parameter int SOFT_RST_CYCLES = 16
) (
    input  logic clk_rgb,
    input  logic rst,
    input  logic downloading_i,
    input  logic rst_req_i,
    output logic soft_rst_o
);

    localparam int CW = $clog2(SOFT_RST_CYCLES + 1);

    logic          dl_q;
    logic [CW-1:0] cnt;     // Cycles left after the current one

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            dl_q       <= 1'b0;
            cnt        <= '0;
            soft_rst_o <= 1'b0;
        end else begin
            dl_q <= downloading_i;
            if (dl_q && !downloading_i) begin   // Download just ended
                cnt        <= CW'(SOFT_RST_CYCLES - 1);
                soft_rst_o <= 1'b1;
            end else if (cnt != '0) begin
                cnt        <= cnt - 1'b1;
                soft_rst_o <= 1'b1;
            end else begin
                soft_rst_o <= rst_req_i;  // Idle, follow the host
            end
        end
    end

endmodule

// ==== hw/rom_store.sv ====
// ****************************************
// Single-port word memory in place of SDRAM
// ****************************************
`timescale 1ns/1ns

module rom_store #(
    parameter int ROM_AW = 11
) (
    input  logic                 clk_rgb,
    input  logic                 en_i,
    input  arcade_pkg::mem_req_t req_i,
    output logic [15:0]          rdata_o
);

    logic [15:0] mem [2**ROM_AW];

    // Registered read, data one cycle after the grant
    always_ff @(posedge clk_rgb) begin
        if (en_i) begin
            if (req_i.we) begin
                mem[req_i.addr[ROM_AW-1:0]] <= req_i.wdata;
            end else begin
                rdata_o <= mem[req_i.addr[ROM_AW-1:0]];
            end
        end
    end

endmodule

// ==== hw/rom_arbiter.sv ====
// ****************************************
// ROM store sharing between loader writes
// and game reads, one pending read slot
// ****************************************
`timescale 1ns/1ns

module rom_arbiter (
    input  logic                 clk_rgb,
    input  logic                 rst,
    input  logic                 wr_stb_i,
    input  arcade_pkg::mem_req_t wr_req_i,
    input  logic                 rd_stb_i,
    input  logic [15:0]          rd_addr_i,
    output logic                 mem_en_o,
    output arcade_pkg::mem_req_t mem_req_o,
    input  logic [15:0]          mem_rdata_i,
    output logic                 rd_valid_o,
    output logic [15:0]          rd_data_o
);
    import arcade_pkg::*;

    logic        pend_vld;
    logic [15:0] pend_addr;
    logic        rd_grant;      // A read owns the store this cycle
    logic        new_grant;
    logic        rd_inflight;   // Store data for a read arrives now
    mem_req_t    rd_req;

    // Writes first, then the older read
    assign new_grant = !wr_stb_i && !pend_vld && rd_stb_i;
    assign rd_grant  = !wr_stb_i && (pend_vld || rd_stb_i);

    assign rd_req.we    = 1'b0;
    assign rd_req.addr  = pend_vld ? pend_addr : rd_addr_i;
    assign rd_req.wdata = '0;

    assign mem_en_o  = wr_stb_i || rd_grant;
    assign mem_req_o = wr_stb_i ? wr_req_i : rd_req;

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            pend_vld    <= 1'b0;
            rd_inflight <= 1'b0;
            rd_valid_o  <= 1'b0;
        end else begin
            if (rd_stb_i && !new_grant) begin
                pend_vld <= 1'b1;       // Lost this cycle, retry next
            end else if (rd_grant) begin
                pend_vld <= 1'b0;
            end
            rd_inflight <= rd_grant;
            rd_valid_o  <= rd_inflight;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (rd_stb_i && !new_grant) pend_addr <= rd_addr_i;
        if (rd_inflight) rd_data_o <= mem_rdata_i;
    end

endmodule

// ==== hw/rom_loader.sv ====
// ****************************************
// Download byte steering: PROM strobes or
// 16-bit ROM write words
// ****************************************
`timescale 1ns/1ns

module rom_loader #(
    parameter int ROM_AW = 11
) (
    input  logic                  clk_rgb,
    input  logic                  rst,
    input  logic                  dl_stb_i,
    input  arcade_pkg::dl_byte_t  dl_i,
    output logic                  prom_stb_o,
    output arcade_pkg::prom_prog_t prom_o,
    output logic                  wr_stb_o,
    output arcade_pkg::mem_req_t  wr_req_o
);
    import arcade_pkg::*;

    localparam int unsigned ROM_BYTES = 2 << ROM_AW;

    logic       is_prom;
    logic       is_rom;
    logic       odd_byte;
    logic [7:0] low_byte;   // Even byte waiting for its partner

    // PROM view first, everything else is checked as a flat address
    assign is_prom  = (dl_i.addr.prom.tag == PROM_TAG);
    assign is_rom   = !is_prom && (32'(dl_i.addr.flat) < ROM_BYTES);
    assign odd_byte = dl_i.addr.flat[0];

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            prom_stb_o <= 1'b0;
            wr_stb_o   <= 1'b0;
        end else begin
            prom_stb_o <= dl_stb_i && is_prom;
            wr_stb_o   <= dl_stb_i && is_rom && odd_byte; // Word complete
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (dl_stb_i && is_prom) begin
            prom_o.we   <= 16'd1 << dl_i.addr.prom.idx;
            prom_o.addr <= dl_i.addr.prom.offset;
            prom_o.data <= dl_i.data[3:0];  // PROMs are 4 bits wide
        end
        if (dl_stb_i && is_rom) begin
            if (!odd_byte) begin
                low_byte <= dl_i.data;
            end else begin
                wr_req_o.we    <= 1'b1;
                wr_req_o.addr  <= {1'b0, dl_i.addr.flat[15:1]};
                wr_req_o.wdata <= {dl_i.data, low_byte}; // High byte on top
            end
        end
    end

endmodule

// ==== hw/arcade_pkg.sv ====
// ****************************************
// Shared types for the arcade board shell:
// download byte, memory request, PROM and input words
// ****************************************
package arcade_pkg;

    localparam logic [3:0] PROM_TAG = 4'hf; // Region tag of the PROM area

    // PROM view of a download address
    typedef struct packed {
        logic [3:0] tag;
        logic [3:0] idx;    // Which PROM
        logic [7:0] offset;
    } prom_addr_t;

    // Same 16 bits, flat ROM byte address or PROM selector
    typedef union packed {
        logic [15:0] flat;
        prom_addr_t  prom;
    } dl_addr_u;

    typedef struct packed {
        dl_addr_u   addr;
        logic [7:0] data;
    } dl_byte_t;

    // One access to the ROM store, as granted by the arbiter
    typedef struct packed {
        logic        we;
        logic [15:0] addr;  // Word address
        logic [15:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [15:0] we;    // One-hot, bit per PROM
        logic [7:0]  addr;
        logic [3:0]  data;
    } prom_prog_t;

    // Active low, as the game expects
    typedef struct packed {
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
    } game_in_t;

    // Active high button sources (joystick or keyboard)
    typedef struct packed {
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
    } btn_in_t;

endpackage
